//--- alu_params.svh
`ifndef ALU_PARAMS_SVH
`define ALU_PARAMS_SVH

// datapath sizes
`define ALU_WIDTH     8 // operand and result byte
`define ALU_OP_BITS   5 // operation code
`define ALU_FLAG_BITS 8 // one bit per flag

// bit positions inside the active low flag vector
`define FLAG_C  0 // carry or borrow out
`define FLAG_Z  1 // result is zero
`define FLAG_N  2 // result sign bit
`define FLAG_O  3 // signed overflow
`define FLAG_GT 4 // a greater than b
`define FLAG_LT 5 // a less than b
`define FLAG_EQ 6 // a equals b
`define FLAG_NE 7 // a differs from b

// all flags inactive
`define FLAGS_IDLE {`ALU_FLAG_BITS{1'b1}}

`endif

//--- alu_pkg.sv
`default_nettype none

`include "alu_params.svh"

package alu_pkg;

    // operation codes of the table
    typedef enum logic [`ALU_OP_BITS-1:0] {
        OP_0                   = 5'd0,
        OP_A                   = 5'd1,  // pass a
        OP_B                   = 5'd2,  // pass b
        OP_NEGATE_A            = 5'd3,
        OP_NEGATE_B            = 5'd4,
        OP_BCD_DIV             = 5'd5,  // {b,a} / 10
        OP_B_PLUS_1            = 5'd6,
        OP_BCD_MOD             = 5'd7,  // {b,a} % 10
        OP_B_MINUS_1           = 5'd8,
        OP_A_PLUS_B            = 5'd9,
        OP_A_MINUS_B           = 5'd10,
        OP_B_MINUS_A           = 5'd11,
        OP_A_MINUS_B_SIGNEDMAG = 5'd12, // compare flags signed
        OP_A_PLUS_B_PLUS_C     = 5'd13, // only picked when carry is set
        OP_A_MINUS_B_MINUS_C   = 5'd14,
        OP_B_MINUS_A_MINUS_C   = 5'd15,
        OP_A_TIMES_B_HI        = 5'd16,
        OP_A_TIMES_B_LO        = 5'd17,
        OP_A_DIV_B             = 5'd18,
        OP_A_MOD_B             = 5'd19,
        OP_A_LSL_B             = 5'd20,
        OP_A_LSR_B             = 5'd21,
        OP_A_ASR_B             = 5'd22,
        OP_A_RLC_B             = 5'd23,
        OP_A_RRC_B             = 5'd24,
        OP_A_OR_B              = 5'd25,
        OP_A_AND_B             = 5'd26,
        OP_A_XOR_B             = 5'd27,
        OP_A_NAND_B            = 5'd28,
        OP_NOT_B               = 5'd29,
        OP_A_PLUS_B_BCD        = 5'd30,
        OP_A_MINUS_B_BCD       = 5'd31
    } alu_op_t;

    // one byte read either as binary or as two decimal digits
    typedef union packed {
        logic [`ALU_WIDTH-1:0] raw;
        struct packed {
            logic [3:0] hi; // tens
            logic [3:0] lo; // units
        } digits;
    } bcd_byte_u;

endpackage

`default_nettype wire

//--- alu_rom.sv
`timescale 1ns/1ps
`default_nettype none

`include "alu_params.svh"

module alu_rom (
    input  wire [`ALU_WIDTH-1:0]     a,
    input  wire [`ALU_WIDTH-1:0]     b,
    input  wire alu_pkg::alu_op_t    op,
    output logic [`ALU_WIDTH-1:0]    result,
    output logic [`ALU_FLAG_BITS-1:0] flags_n
);

    //////////////////////////////////////////////////
    // overflow rules

    // like signs in and the other sign out
    function automatic logic add_ovf(input logic l, input logic r, input logic s);
        return (l == r) && (s != l);
    endfunction

    // unlike signs in and the result lost the sign of the left side
    function automatic logic sub_ovf(input logic l, input logic r, input logic s);
        return (l != r) && (s != l);
    endfunction

    logic [`ALU_WIDTH:0] res9;       // carry sits on top of the result byte
    logic                ovf;        // active high until the output stage
    logic                signed_cmp; // gt/lt use two's complement
    logic                neg;

    logic [2*`ALU_WIDTH-1:0] prod;     // a * b full width
    logic [2*`ALU_WIDTH-1:0] bcd_word; // b is the high byte
    logic [2*`ALU_WIDTH-1:0] bcd_q;
    logic [2*`ALU_WIDTH-1:0] bcd_r;
    logic [`ALU_WIDTH-1:0]   div_q;
    logic [`ALU_WIDTH-1:0]   div_r;

    logic                    big_shift; // count of 8 or more
    logic [`ALU_WIDTH:0]     lsl_w;     // carry in bit 8
    logic [`ALU_WIDTH:0]     lsr_w;     // carry in bit 0
    logic signed [`ALU_WIDTH+1:0] asr_w; // sign copy on top and carry in bit 0
    logic [2*`ALU_WIDTH-1:0] rol_w;     // doubled byte for rotation
    logic [2*`ALU_WIDTH-1:0] ror_w;
    logic                    rot_zero;

    alu_pkg::bcd_byte_u    a_bcd;
    alu_pkg::bcd_byte_u    b_bcd;
    alu_pkg::bcd_byte_u    sum_bcd;
    alu_pkg::bcd_byte_u    dif_bcd;
    logic [`ALU_WIDTH-1:0] a_dec;       // decimal value of a
    logic [`ALU_WIDTH-1:0] b_dec;
    logic [`ALU_WIDTH:0]   bcd_sum;     // up to 198 for valid digits
    logic [`ALU_WIDTH:0]   bcd_sum_rem;
    logic [`ALU_WIDTH-1:0] bcd_dif;     // a + (100 - b) wraps at 256
    logic [`ALU_WIDTH-1:0] bcd_dif_rem;

    //////////////////////////////////////////////////
    // shared arithmetic

    assign prod     = a * b;
    assign bcd_word = {b, a};
    assign bcd_q    = bcd_word / 16'd10;
    assign bcd_r    = bcd_word % 16'd10;
    assign div_q    = (b == '0) ? '0 : a / b; // div by zero handled below
    assign div_r    = (b == '0) ? '0 : a % b;

    assign big_shift = (b >= `ALU_WIDTH);
    assign lsl_w     = {1'b0, a} << b[2:0];
    assign lsr_w     = {a, 1'b0} >> b[2:0];
    assign asr_w     = $signed({a[`ALU_WIDTH-1], a, 1'b0}) >>> b[2:0];
    assign rol_w     = {a, a} << b[2:0]; // result in the high byte
    assign ror_w     = {a, a} >> b[2:0]; // result in the low byte
    assign rot_zero  = (b[2:0] == 3'd0); // rotate count mod 8

    // bcd digits to binary
    assign a_bcd.raw = a;
    assign b_bcd.raw = b;
    assign a_dec     = a_bcd.digits.hi * 8'd10 + a_bcd.digits.lo;
    assign b_dec     = b_bcd.digits.hi * 8'd10 + b_bcd.digits.lo;

    assign bcd_sum        = a_dec + b_dec;
    assign bcd_sum_rem    = bcd_sum % 9'd100;
    assign sum_bcd.digits = {4'(bcd_sum_rem / 9'd10), 4'(bcd_sum_rem % 9'd10)};

    // add the complement so no wrap below zero is needed
    assign bcd_dif        = a_dec + (8'd100 - b_dec);
    assign bcd_dif_rem    = bcd_dif % 8'd100;
    assign dif_bcd.digits = {4'(bcd_dif_rem / 8'd10), 4'(bcd_dif_rem % 8'd10)};

    //////////////////////////////////////////////////
    // operation table

    always_comb begin
        res9 = '0;   // also the answer for unlisted codes
        ovf  = 1'b0;
        case (op)
            alu_pkg::OP_0: res9 = '0;
            alu_pkg::OP_A: res9 = {1'b0, a};
            alu_pkg::OP_B: res9 = {1'b0, b};
            alu_pkg::OP_NEGATE_A: begin
                res9 = {1'b0, 8'(-a)};
                ovf  = (a == 8'h80); // -128 has no positive form
            end
            alu_pkg::OP_NEGATE_B: begin
                res9 = {1'b0, 8'(-b)};
                ovf  = (b == 8'h80);
            end
            alu_pkg::OP_BCD_DIV: begin
                if (b < 8'd10) res9 = {1'b0, bcd_q[`ALU_WIDTH-1:0]};
                else           ovf  = 1'b1; // quotient would not fit a byte
            end
            alu_pkg::OP_B_PLUS_1: begin
                res9 = {1'b0, b} + 9'd1; // makes carry but never consumes it
                ovf  = add_ovf(b[7], 1'b0, res9[7]);
            end
            alu_pkg::OP_BCD_MOD: begin
                if (b < 8'd10) res9 = {1'b0, bcd_r[`ALU_WIDTH-1:0]};
                else           ovf  = 1'b1;
            end
            alu_pkg::OP_B_MINUS_1: begin
                res9 = {1'b0, b} - 9'd1;
                ovf  = sub_ovf(b[7], 1'b0, res9[7]);
            end
            alu_pkg::OP_A_PLUS_B: begin
                res9 = {1'b0, a} + {1'b0, b};
                ovf  = add_ovf(a[7], b[7], res9[7]);
            end
            alu_pkg::OP_A_MINUS_B,
            alu_pkg::OP_A_MINUS_B_SIGNEDMAG: begin
                res9 = {1'b0, a} - {1'b0, b}; // borrow lands in bit 8
                ovf  = sub_ovf(a[7], b[7], res9[7]);
            end
            alu_pkg::OP_B_MINUS_A: begin
                res9 = {1'b0, b} - {1'b0, a};
                ovf  = sub_ovf(b[7], a[7], res9[7]);
            end
            alu_pkg::OP_A_PLUS_B_PLUS_C: begin
                res9 = {1'b0, a} + {1'b0, b} + 9'd1;
                ovf  = add_ovf(a[7], b[7], res9[7]);
            end
            alu_pkg::OP_A_MINUS_B_MINUS_C: begin
                res9 = {1'b0, a} - {1'b0, b} - 9'd1;
                ovf  = sub_ovf(a[7], b[7], res9[7]);
            end
            alu_pkg::OP_B_MINUS_A_MINUS_C: begin
                res9 = {1'b0, b} - {1'b0, a} - 9'd1;
                ovf  = sub_ovf(b[7], a[7], res9[7]);
            end
            alu_pkg::OP_A_TIMES_B_HI: res9 = {1'b0, prod[15:8]};
            alu_pkg::OP_A_TIMES_B_LO: res9 = {|prod[15:8], prod[7:0]}; // carry when high byte used
            alu_pkg::OP_A_DIV_B: begin
                res9 = {1'b0, div_q};
                if (b == '0) begin
                    res9 = 9'h100; // zero with carry forced
                    ovf  = 1'b1;
                end
            end
            alu_pkg::OP_A_MOD_B: begin
                res9 = {1'b0, div_r};
                if (b == '0) begin
                    res9 = 9'h100;
                    ovf  = 1'b1;
                end
            end
            // shifts of 8 or more clear result and carry
            alu_pkg::OP_A_LSL_B: begin // c <- a <- 0
                if (!big_shift) res9 = lsl_w;
                ovf = (a[7] != res9[7]);
            end
            alu_pkg::OP_A_LSR_B: begin // 0 -> a -> c
                if (!big_shift) res9 = {lsr_w[0], lsr_w[8:1]};
                ovf = (a[7] != res9[7]);
            end
            alu_pkg::OP_A_ASR_B: begin // sign fill from the left
                if (!big_shift) res9 = {asr_w[0], asr_w[8:1]};
                ovf = (a[7] != res9[7]);
            end
            alu_pkg::OP_A_RLC_B: begin
                res9 = {~rot_zero & rol_w[8], rol_w[15:8]}; // last wrap is the new lsb
                ovf  = (a[7] != res9[7]);
            end
            alu_pkg::OP_A_RRC_B: begin
                res9 = {~rot_zero & ror_w[7], ror_w[7:0]}; // last wrap is the new msb
                ovf  = (a[7] != res9[7]);
            end
            alu_pkg::OP_A_OR_B:   res9 = {1'b0, a | b};
            alu_pkg::OP_A_AND_B:  res9 = {1'b0, a & b};
            alu_pkg::OP_A_XOR_B:  res9 = {1'b0, a ^ b};
            alu_pkg::OP_A_NAND_B: res9 = {1'b0, ~(a & b)};
            alu_pkg::OP_NOT_B:    res9 = {1'b0, ~b};
            alu_pkg::OP_A_PLUS_B_BCD: begin // no carry in
                res9 = {(bcd_sum >= 9'd100), sum_bcd.raw};
            end
            alu_pkg::OP_A_MINUS_B_BCD: begin // no borrow in
                res9 = {(bcd_dif < 8'd100), dif_bcd.raw};
            end
            default: begin
                res9 = '0;
                ovf  = 1'b0;
            end
        endcase
    end

    //////////////////////////////////////////////////
    // flag outputs, all active low

    assign signed_cmp = (op == alu_pkg::OP_A_MINUS_B_SIGNEDMAG);

    // bcd subtract reports sign from the operand order only
    assign neg = (op == alu_pkg::OP_A_MINUS_B_BCD) ? (b > a) : res9[7];

    assign result = res9[`ALU_WIDTH-1:0];

    assign flags_n[`FLAG_C]  = ~res9[`ALU_WIDTH];
    assign flags_n[`FLAG_Z]  = ~(res9[`ALU_WIDTH-1:0] == '0);
    assign flags_n[`FLAG_N]  = ~neg;
    assign flags_n[`FLAG_O]  = ~ovf;
    assign flags_n[`FLAG_GT] = signed_cmp ? ~($signed(a) > $signed(b)) : ~(a > b);
    assign flags_n[`FLAG_LT] = signed_cmp ? ~($signed(a) < $signed(b)) : ~(a < b);
    assign flags_n[`FLAG_EQ] = ~(a == b);
    assign flags_n[`FLAG_NE] = ~(a != b);

endmodule

`default_nettype wire

//--- alu_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

`include "alu_params.svh"

module alu_sequencer (
    input  wire                       clk,
    input  wire                       rst_n,
    input  wire                       req,
    input  wire alu_pkg::alu_op_t     op,
    input  wire [`ALU_WIDTH-1:0]      a,
    input  wire [`ALU_WIDTH-1:0]      b,
    input  wire                       use_carry,   // fold stored carry into add/sub
    input  wire [`ALU_WIDTH-1:0]      rom_result,
    input  wire [`ALU_FLAG_BITS-1:0]  rom_flags_n,
    output logic                      ack,
    output alu_pkg::alu_op_t          op_eff,      // table operation after carry mapping
    output logic [`ALU_WIDTH-1:0]     a_q,
    output logic [`ALU_WIDTH-1:0]     b_q,
    output logic [`ALU_WIDTH-1:0]     result,
    output logic [`ALU_FLAG_BITS-1:0] flags_n
);

    // handshake states
    localparam logic [1:0] ST_IDLE = 2'd0; // waiting for req
    localparam logic [1:0] ST_EVAL = 2'd1; // table settling on latched operands
    localparam logic [1:0] ST_DONE = 2'd2; // ack high until req drops

    logic [1:0]       state;
    logic             accept;    // new operation taken this edge
    logic             carry_set; // stored carry is active
    alu_pkg::alu_op_t op_sel;

    assign accept    = (state == ST_IDLE) && req;
    assign carry_set = ~flags_n[`FLAG_C]; // carry from the previous operation

    //////////////////////////////////////////////////
    // carry variant selection

    always_comb begin
        op_sel = op; // most codes pass unchanged
        if (use_carry && carry_set) begin
            case (op)
                alu_pkg::OP_A_PLUS_B:  op_sel = alu_pkg::OP_A_PLUS_B_PLUS_C;
                alu_pkg::OP_A_MINUS_B: op_sel = alu_pkg::OP_A_MINUS_B_MINUS_C;
                alu_pkg::OP_B_MINUS_A: op_sel = alu_pkg::OP_B_MINUS_A_MINUS_C;
                default:               op_sel = op;
            endcase
        end
    end

    //////////////////////////////////////////////////
    // handshake FSM

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= ST_IDLE;
            ack   <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (accept) state <= ST_EVAL; // operands latched on this edge
                end
                ST_EVAL: begin
                    state <= ST_DONE;
                    ack   <= 1'b1; // result captured on the same edge
                end
                ST_DONE: begin
                    if (!req) begin // four-phase release
                        state <= ST_IDLE;
                        ack   <= 1'b0;
                    end
                end
                default: begin
                    state <= ST_IDLE;
                    ack   <= 1'b0;
                end
            endcase
        end
    end

    // operand latch feeding the table
    always_ff @(posedge clk) begin
        if (accept) begin
            a_q    <= a;
            b_q    <= b;
            op_eff <= op_sel;
        end
    end

    // result and flags persist between operations for chained carry
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            result  <= '0;
            flags_n <= `FLAGS_IDLE; // every flag inactive
        end else if (state == ST_EVAL) begin
            result  <= rom_result;
            flags_n <= rom_flags_n;
        end
    end

endmodule

`default_nettype wire

//--- alu_unit.sv
`timescale 1ns/1ps
`default_nettype none

`include "alu_params.svh"

module alu_unit (
    input  wire                       clk,
    input  wire                       rst_n,
    input  wire                       req,
    output logic                      ack,
    input  wire alu_pkg::alu_op_t     op,
    input  wire [`ALU_WIDTH-1:0]      a,
    input  wire [`ALU_WIDTH-1:0]      b,
    input  wire                       use_carry,
    output logic [`ALU_WIDTH-1:0]     result,
    output logic [`ALU_FLAG_BITS-1:0] flags_n  // active low
);

    // sequencer to table
    alu_pkg::alu_op_t          op_eff;
    logic [`ALU_WIDTH-1:0]     a_q;
    logic [`ALU_WIDTH-1:0]     b_q;
    // table back to sequencer
    logic [`ALU_WIDTH-1:0]     rom_result;
    logic [`ALU_FLAG_BITS-1:0] rom_flags_n;

    alu_sequencer seq0 (
        .clk         (clk),
        .rst_n       (rst_n),
        .req         (req),
        .op          (op),
        .a           (a),
        .b           (b),
        .use_carry   (use_carry),
        .rom_result  (rom_result),
        .rom_flags_n (rom_flags_n),
        .ack         (ack),
        .op_eff      (op_eff),
        .a_q         (a_q),
        .b_q         (b_q),
        .result      (result),
        .flags_n     (flags_n)
    );

    alu_rom rom0 (
        .a       (a_q),
        .b       (b_q),
        .op      (op_eff),
        .result  (rom_result),
        .flags_n (rom_flags_n)  // zero latency
    );

endmodule

`default_nettype wire

//--- tb_alu_unit.sv
`timescale 1ns/1ps
`default_nettype none

`include "alu_params.svh"

module tb_alu_unit;

    localparam int MAX_ROWS  = 64;
    localparam int RAND_ROWS = 8;
    localparam int RST_CYC   = 3;

    logic                      clk;
    logic                      rst_n;
    logic                      req;
    logic                      ack;
    alu_pkg::alu_op_t          op;
    logic [`ALU_WIDTH-1:0]     a;
    logic [`ALU_WIDTH-1:0]     b;
    logic                      use_carry;
    logic [`ALU_WIDTH-1:0]     result;
    logic [`ALU_FLAG_BITS-1:0] flags_n;

    // vector table
    alu_pkg::alu_op_t          tbl_op  [MAX_ROWS];
    logic [`ALU_WIDTH-1:0]     tbl_a   [MAX_ROWS];
    logic [`ALU_WIDTH-1:0]     tbl_b   [MAX_ROWS];
    logic                      tbl_uc  [MAX_ROWS];
    logic [`ALU_WIDTH-1:0]     tbl_res [MAX_ROWS];
    logic [`ALU_FLAG_BITS-1:0] tbl_flg [MAX_ROWS];
    int                        n_rows;
    logic                      table_built;
    integer                    seed;

    alu_unit dut0 (
        .clk       (clk),
        .rst_n     (rst_n),
        .req       (req),
        .ack       (ack),
        .op        (op),
        .a         (a),
        .b         (b),
        .use_carry (use_carry),
        .result    (result),
        .flags_n   (flags_n)
    );

    always #20 clk = ~clk; // 40 ns period

    //////////////////////////////////////////////////
    // expected values

    // active low flag word from the active high pieces
    function automatic logic [`ALU_FLAG_BITS-1:0] expect_flags(
        input logic [`ALU_WIDTH-1:0] res, input logic c, input logic n, input logic o,
        input logic [`ALU_WIDTH-1:0] l, input logic [`ALU_WIDTH-1:0] r, input logic sgn);
        logic [`ALU_FLAG_BITS-1:0] f;
        logic [`ALU_WIDTH-1:0]     lk; // offset binary when signed, so plain compare orders it
        logic [`ALU_WIDTH-1:0]     rk;
        lk = sgn ? (l ^ 8'h80) : l;
        rk = sgn ? (r ^ 8'h80) : r;
        f[`FLAG_C]  = ~c;
        f[`FLAG_Z]  = ~(res == 8'h00);
        f[`FLAG_N]  = ~n;
        f[`FLAG_O]  = ~o;
        f[`FLAG_GT] = ~(lk > rk);
        f[`FLAG_LT] = ~(lk < rk);
        f[`FLAG_EQ] = ~(l == r);
        f[`FLAG_NE] = ~(l != r);
        return f;
    endfunction

    // decimal 0..99 as two bcd digits
    function automatic logic [`ALU_WIDTH-1:0] to_bcd(input int unsigned v);
        alu_pkg::bcd_byte_u d;
        d.digits.hi = 4'(v / 10); // tens
        d.digits.lo = 4'(v % 10);
        return d.raw;
    endfunction

    task automatic add_row(input alu_pkg::alu_op_t o_in, input logic [7:0] a_in,
                           input logic [7:0] b_in, input logic uc, input logic [7:0] res,
                           input logic c, input logic n, input logic o);
        tbl_op[n_rows]  = o_in;
        tbl_a[n_rows]   = a_in;
        tbl_b[n_rows]   = b_in;
        tbl_uc[n_rows]  = uc;
        tbl_res[n_rows] = res;
        tbl_flg[n_rows] = expect_flags(res, c, n, o, a_in, b_in,
                                       o_in == alu_pkg::OP_A_MINUS_B_SIGNEDMAG);
        n_rows++;
    endtask

    // random rows, add/sub/logic without carry in
    task automatic add_random_row();
        alu_pkg::alu_op_t ro;
        logic [7:0] ra;
        logic [7:0] rb;
        logic [7:0] res;
        int         u;  // outcome as unsigned numbers
        int         sv; // outcome as signed numbers
        ra = 8'($random(seed));
        rb = 8'($random(seed));
        u  = 0;
        sv = 0;
        case (($random(seed) & 32'h7fff_ffff) % 4)
            0: begin
                ro = alu_pkg::OP_A_PLUS_B;
                u  = int'(ra) + int'(rb);                   // above 255 is a carry
                sv = int'($signed(ra)) + int'($signed(rb));
            end
            1: begin
                ro = alu_pkg::OP_A_MINUS_B;
                u  = int'(ra) - int'(rb);                   // below 0 is a borrow
                sv = int'($signed(ra)) - int'($signed(rb));
            end
            2: begin
                ro = alu_pkg::OP_A_XOR_B;
                u  = ra ^ rb;
            end
            default: begin
                ro = alu_pkg::OP_A_AND_B;
                u  = ra & rb;
            end
        endcase
        res = 8'(u);
        add_row(ro, ra, rb, 1'b0, res, (u > 255) || (u < 0), res[7],
                (sv > 127) || (sv < -128)); // signed range of a byte
    endtask

    //////////////////////////////////////////////////
    // checks

    task automatic error_out(input string msg);
        $display("** Error at %0t ns: %s", $time, msg);
        $display("Done: errors found");
        $fatal(1, "check failed");
    endtask

    task automatic check_result(input logic [`ALU_WIDTH-1:0] got,
                                input logic [`ALU_WIDTH-1:0] exp, input int row);
        if (got !== exp)
            error_out($sformatf("row %0d result %02h, expected %02h", row, got, exp));
    endtask

    task automatic check_flags(input logic [`ALU_FLAG_BITS-1:0] got,
                               input logic [`ALU_FLAG_BITS-1:0] exp, input int row);
        if (got !== exp)
            error_out($sformatf("row %0d flags_n %08b, expected %08b", row, got, exp));
    endtask

    task automatic check_ack(input logic got, input logic exp, input string where);
        if (got !== exp)
            error_out($sformatf("ack %b %s, expected %b", got, where, exp));
    endtask

    // one four-phase transfer, ack due two edges after req is sampled
    task automatic run_row(input int i);
        int edges;
        @(negedge clk);
        op        = tbl_op[i];
        a         = tbl_a[i];
        b         = tbl_b[i];
        use_carry = tbl_uc[i];
        req       = 1'b1;
        edges     = 0;
        while (ack !== 1'b1) begin // one rising edge passes per loop
            @(negedge clk);
            edges++;
        end
        if (edges != 2)
            error_out($sformatf("row %0d ack rose %0d edges after req, expected 2",
                                i, edges));
        check_result(result, tbl_res[i], i);
        check_flags(flags_n, tbl_flg[i], i);
        req = 1'b0;
        @(negedge clk);
        check_ack(ack, 1'b0, "after req dropped");
    endtask

    //////////////////////////////////////////////////
    // table and main sequence

    initial begin
        clk         = 1'b0;
        rst_n       = 1'b0;
        req         = 1'b0;
        op          = alu_pkg::OP_0;
        a           = '0;
        b           = '0;
        use_carry   = 1'b0;
        n_rows      = 0;
        table_built = 1'b0;
        seed        = 32'h110f_ec46;

        //       op                                  a      b      uc    res    c     n     o
        add_row(alu_pkg::OP_A_PLUS_B,             8'h12, 8'h34, 1'b0, 8'h46, 1'b0, 1'b0, 1'b0);
        add_row(alu_pkg::OP_A_PLUS_B,             8'h7F, 8'h01, 1'b0, 8'h80, 1'b0, 1'b1, 1'b1);
        add_row(alu_pkg::OP_A_MINUS_B,            8'h10, 8'h20, 1'b0, 8'hF0, 1'b1, 1'b1, 1'b0);
        add_row(alu_pkg::OP_B_MINUS_A,            8'h10, 8'h30, 1'b0, 8'h20, 1'b0, 1'b0, 1'b0);
        add_row(alu_pkg::OP_B_PLUS_1,             8'h00, 8'hFF, 1'b0, 8'h00, 1'b1, 1'b0, 1'b0);
        add_row(alu_pkg::OP_B_MINUS_1,            8'h00, 8'h80, 1'b0, 8'h7F, 1'b0, 1'b0, 1'b1);
        add_row(alu_pkg::OP_NEGATE_A,             8'h80, 8'h00, 1'b0, 8'h80, 1'b0, 1'b1, 1'b1);
        add_row(alu_pkg::OP_NEGATE_B,             8'h00, 8'h05, 1'b0, 8'hFB, 1'b0, 1'b1, 1'b0);
        // chained carry, then the same add without it
        add_row(alu_pkg::OP_A_PLUS_B,             8'hFF, 8'h01, 1'b1, 8'h00, 1'b1, 1'b0, 1'b0);
        add_row(alu_pkg::OP_A_PLUS_B,             8'h00, 8'h00, 1'b1, 8'h01, 1'b0, 1'b0, 1'b0);
        add_row(alu_pkg::OP_A_PLUS_B,             8'hFF, 8'h01, 1'b0, 8'h00, 1'b1, 1'b0, 1'b0);
        add_row(alu_pkg::OP_A_PLUS_B,             8'h00, 8'h00, 1'b0, 8'h00, 1'b0, 1'b0, 1'b0);
        // borrow chained into both subtract forms
        add_row(alu_pkg::OP_A_MINUS_B,            8'h00, 8'h01, 1'b0, 8'hFF, 1'b1, 1'b1, 1'b0);
        add_row(alu_pkg::OP_A_MINUS_B,            8'h00, 8'h01, 1'b1, 8'hFE, 1'b1, 1'b1, 1'b0);
        add_row(alu_pkg::OP_B_MINUS_A,            8'h05, 8'h02, 1'b1, 8'hFC, 1'b1, 1'b1, 1'b0);
        // multiply, divide, bcd divide
        add_row(alu_pkg::OP_A_TIMES_B_HI,         8'h20, 8'h10, 1'b0, 8'h02, 1'b0, 1'b0, 1'b0);
        add_row(alu_pkg::OP_A_TIMES_B_LO,         8'h20, 8'h10, 1'b0, 8'h00, 1'b1, 1'b0, 1'b0);
        add_row(alu_pkg::OP_A_DIV_B,              8'd100, 8'd7, 1'b0, 8'h0E, 1'b0, 1'b0, 1'b0);
        add_row(alu_pkg::OP_A_MOD_B,              8'd100, 8'd7, 1'b0, 8'h02, 1'b0, 1'b0, 1'b0);
        add_row(alu_pkg::OP_A_DIV_B,              8'h55, 8'h00, 1'b0, 8'h00, 1'b1, 1'b0, 1'b1);
        add_row(alu_pkg::OP_A_MOD_B,              8'h55, 8'h00, 1'b0, 8'h00, 1'b1, 1'b0, 1'b1);
        add_row(alu_pkg::OP_BCD_DIV,              8'h34, 8'h02, 1'b0, 8'h38, 1'b0, 1'b0, 1'b0);
        add_row(alu_pkg::OP_BCD_MOD,              8'h34, 8'h02, 1'b0, 8'h04, 1'b0, 1'b0, 1'b0);
        add_row(alu_pkg::OP_BCD_DIV,              8'h34, 8'h0A, 1'b0, 8'h00, 1'b0, 1'b0, 1'b1);
        add_row(alu_pkg::OP_BCD_MOD,              8'h34, 8'h0B, 1'b0, 8'h00, 1'b0, 1'b0, 1'b1);
        // shifts and rotates of 1001_0110, overflow when the msb changes
        add_row(alu_pkg::OP_A_LSL_B,              8'h96, 8'd0, 1'b0, 8'h96, 1'b0, 1'b1, 1'b0);
        add_row(alu_pkg::OP_A_LSL_B,              8'h96, 8'd3, 1'b0, 8'hB0, 1'b0, 1'b1, 1'b0);
        add_row(alu_pkg::OP_A_LSL_B,              8'h96, 8'd9, 1'b0, 8'h00, 1'b0, 1'b0, 1'b1);
        add_row(alu_pkg::OP_A_LSR_B,              8'h96, 8'd3, 1'b0, 8'h12, 1'b1, 1'b0, 1'b1);
        add_row(alu_pkg::OP_A_ASR_B,              8'h96, 8'd3, 1'b0, 8'hF2, 1'b1, 1'b1, 1'b0);
        add_row(alu_pkg::OP_A_ASR_B,              8'h96, 8'd9, 1'b0, 8'h00, 1'b0, 1'b0, 1'b1);
        add_row(alu_pkg::OP_A_RLC_B,              8'h96, 8'd3, 1'b0, 8'hB4, 1'b0, 1'b1, 1'b0);
        add_row(alu_pkg::OP_A_RRC_B,              8'h96, 8'd3, 1'b0, 8'hD2, 1'b1, 1'b1, 1'b0);
        add_row(alu_pkg::OP_A_RLC_B,              8'h96, 8'd9, 1'b0, 8'h2D, 1'b1, 1'b0, 1'b1);
        add_row(alu_pkg::OP_A_RRC_B,              8'h96, 8'd0, 1'b0, 8'h96, 1'b0, 1'b1, 1'b0);
        // logic
        add_row(alu_pkg::OP_A_OR_B,               8'hC3, 8'h5A, 1'b0, 8'hDB, 1'b0, 1'b1, 1'b0);
        add_row(alu_pkg::OP_A_AND_B,              8'hC3, 8'h5A, 1'b0, 8'h42, 1'b0, 1'b0, 1'b0);
        add_row(alu_pkg::OP_A_XOR_B,              8'hC3, 8'h5A, 1'b0, 8'h99, 1'b0, 1'b1, 1'b0);
        add_row(alu_pkg::OP_A_NAND_B,             8'hC3, 8'h5A, 1'b0, 8'hBD, 1'b0, 1'b1, 1'b0);
        add_row(alu_pkg::OP_NOT_B,                8'hC3, 8'h5A, 1'b0, 8'hA5, 1'b0, 1'b1, 1'b0);
        // bcd, negative from operand order on subtract
        add_row(alu_pkg::OP_A_PLUS_B_BCD,  to_bcd(99), to_bcd(1), 1'b0, to_bcd(0),
                1'b1, 1'b0, 1'b0);
        add_row(alu_pkg::OP_A_PLUS_B_BCD,  to_bcd(25), to_bcd(48), 1'b0, to_bcd(73),
                1'b0, 1'b0, 1'b0);
        add_row(alu_pkg::OP_A_MINUS_B_BCD, to_bcd(10), to_bcd(20), 1'b0, to_bcd(90),
                1'b1, 1'b1, 1'b0); // 10 - 20 wraps to 90 with borrow
        add_row(alu_pkg::OP_A_MINUS_B_BCD, to_bcd(45), to_bcd(12), 1'b0, to_bcd(33),
                1'b0, 1'b0, 1'b0);
        // signed vs unsigned compare of 0x80 against 0x01
        add_row(alu_pkg::OP_A_MINUS_B_SIGNEDMAG,  8'h80, 8'h01, 1'b0, 8'h7F, 1'b0, 1'b0, 1'b1);
        add_row(alu_pkg::OP_A_MINUS_B,            8'h80, 8'h01, 1'b0, 8'h7F, 1'b0, 1'b0, 1'b1);
        add_row(alu_pkg::OP_0,                    8'h44, 8'h44, 1'b0, 8'h00, 1'b0, 1'b0, 1'b0);
        for (int i = 0; i < RAND_ROWS; i++) add_random_row();
        table_built = 1'b1;

        repeat (RST_CYC) @(negedge clk);
        // reset values before release
        check_ack(ack, 1'b0, "in reset");
        check_result(result, 8'h00, -1);
        check_flags(flags_n, `FLAGS_IDLE, -1);
        rst_n = 1'b1;

        for (int i = 0; i < n_rows; i++) run_row(i);

        $display("Done: no errors");
        $finish;
    end

    // watchdog, ten cycles per row plus reset
    initial begin
        wait (table_built);
        #((n_rows * 10 + RST_CYC + 2) * 40);
        $display("timeout: ack never arrived for a pending request");
        $display("Done: errors found");
        $fatal(1, "watchdog expired");
    end

endmodule

`default_nettype wire

//--- sim.f
+incdir+.
alu_pkg.sv
alu_rom.sv
alu_sequencer.sv
alu_unit.sv
tb_alu_unit.sv

//--- Makefile
VERILATOR  ?= verilator
TOP        := tb_alu_unit
FILELIST   := sim.f
OBJ_DIR    := obj_dir
SIM_FLAGS  := --binary --timing -Wno-fatal -j 0
LINT_FLAGS := --lint-only --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# exit status of the simulator is the pass or fail result
run: build
	./$(OBJ_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
